//--- brisc_core_pkg.sv
`default_nettype none

package brisc_core_pkg;

  // Datapath widths
  localparam int XLEN = 32;
  localparam int ILEN = 32;
  localparam int ADDRESS_WIDTH = 32;

  // Sequential fetch step
  localparam logic [XLEN-1:0] PC_INCREMENT = XLEN'(ILEN / 8);

  // Reset and trap addresses
  localparam logic [ADDRESS_WIDTH-1:0] PC_BOOT = 32'h0000_0100;
  localparam logic [ADDRESS_WIDTH-1:0] PC_XCPT = 32'h0000_0040;

  // Where the next PC comes from
  typedef enum logic {
    FROM_PC4 = 1'b0,
    FROM_A   = 1'b1
  } pc_src_e;

  // Anything other than NO_XCPT sends fetch to the vector
  typedef enum logic [1:0] {
    NO_XCPT      = 2'd0,
    XCPT_ILLEGAL = 2'd1,
    XCPT_ECALL   = 2'd2
  } xcpt_e;

endpackage

`default_nettype wire

//--- brisc_mem_pkg.sv
`default_nettype none

package brisc_mem_pkg;

  // One line holds four instructions
  localparam int CACHE_LINE_WIDTH = 128;
  localparam int LINE_BYTES = CACHE_LINE_WIDTH / 8;
  localparam int LINE_OFFSET_WIDTH = $clog2(LINE_BYTES);
  localparam int WORDS_PER_LINE = CACHE_LINE_WIDTH / brisc_core_pkg::ILEN;
  localparam int WORD_SEL_WIDTH = $clog2(WORDS_PER_LINE);

  // Line-aligned request; word 0 of a line sits in the low bits of data
  typedef struct packed {
    logic [brisc_core_pkg::ADDRESS_WIDTH-1:0] addr;
    logic                                     write;
    logic [CACHE_LINE_WIDTH-1:0]              data;
  } mem_req_t;

  // valid is a single-cycle pulse seen by every requester
  typedef struct packed {
    logic                                     valid;
    logic [brisc_core_pkg::ADDRESS_WIDTH-1:0] addr;
    logic [CACHE_LINE_WIDTH-1:0]              data;
  } mem_resp_t;

  // Owner of the memory port
  typedef enum logic {
    REQ_ICACHE = 1'b0,
    REQ_DATA   = 1'b1
  } requester_e;

endpackage

`default_nettype wire

//--- icache.sv
`timescale 1ns/1ps
`default_nettype none

module icache #(
  parameter int NUM_LINES = 16
) (
  input  wire logic                                          clk,
  input  wire logic                                          reset,
  input  wire logic [brisc_core_pkg::ADDRESS_WIDTH-1:0]      addr,
  output logic [brisc_core_pkg::ILEN-1:0]                    read_data,
  output logic                                               miss,
  output logic                                               req,
  output brisc_mem_pkg::mem_req_t                            mem_req,
  input  wire logic                                          grant,
  input  wire brisc_mem_pkg::mem_resp_t                      mem_resp
);

  localparam int AW = brisc_core_pkg::ADDRESS_WIDTH;
  localparam int LINE_WIDTH = brisc_mem_pkg::CACHE_LINE_WIDTH;
  localparam int OFFSET_WIDTH = brisc_mem_pkg::LINE_OFFSET_WIDTH;
  localparam int WORD_SEL_WIDTH = brisc_mem_pkg::WORD_SEL_WIDTH;
  localparam int BYTE_SEL_WIDTH = OFFSET_WIDTH - WORD_SEL_WIDTH;
  localparam int INDEX_WIDTH = $clog2(NUM_LINES);
  localparam int TAG_WIDTH = AW - INDEX_WIDTH - OFFSET_WIDTH;

  typedef enum logic [1:0] {
    IDLE,
    REQUEST,
    WAIT_RESP,
    FILL
  } state_e;

  state_e state;
  state_e state_next;

  logic [TAG_WIDTH-1:0]  tag_mem  [NUM_LINES];
  logic [LINE_WIDTH-1:0] line_mem [NUM_LINES];
  logic [NUM_LINES-1:0]  valid;

  logic [INDEX_WIDTH-1:0]    index;
  logic [TAG_WIDTH-1:0]      tag;
  logic [WORD_SEL_WIDTH-1:0] word_sel;
  logic [AW-1:0]             line_addr;

  logic [AW-1:0]          req_addr;
  logic [INDEX_WIDTH-1:0] fill_index;
  logic [TAG_WIDTH-1:0]   fill_tag;
  logic [LINE_WIDTH-1:0]  fill_data;
  logic                   resp_match;

  logic                  array_hit;
  logic                  fill_hit;
  logic [LINE_WIDTH-1:0] line;

  // Address split
  assign index     = addr[OFFSET_WIDTH +: INDEX_WIDTH];
  assign tag       = addr[AW-1 -: TAG_WIDTH];
  assign word_sel  = addr[BYTE_SEL_WIDTH +: WORD_SEL_WIDTH];
  assign line_addr = {addr[AW-1:OFFSET_WIDTH], {OFFSET_WIDTH{1'b0}}};

  assign fill_index = req_addr[OFFSET_WIDTH +: INDEX_WIDTH];
  assign fill_tag   = req_addr[AW-1 -: TAG_WIDTH];

  // Lookup; the line being filled already counts as a hit
  assign array_hit = valid[index] && (tag_mem[index] == tag);
  assign fill_hit  = (state == FILL) && (line_addr == req_addr);
  assign miss      = !(array_hit || fill_hit);

  assign line      = fill_hit ? fill_data : line_mem[index];
  assign read_data = line[word_sel*brisc_core_pkg::ILEN +: brisc_core_pkg::ILEN];

  assign resp_match = mem_resp.valid && (mem_resp.addr == req_addr);

  // Refill request, always a read
  assign req = (state == REQUEST);

  always_comb begin
    mem_req       = '0;
    mem_req.addr  = req_addr;
    mem_req.write = 1'b0;
  end

  always_comb begin
    state_next = state;
    case (state)
      IDLE: begin
        if (miss) begin
          state_next = REQUEST;
        end
      end
      REQUEST: begin
        if (grant) begin
          state_next = WAIT_RESP;
        end
      end
      WAIT_RESP: begin
        if (resp_match) begin
          state_next = FILL;
        end
      end
      FILL: begin
        state_next = IDLE;
      end
      default: begin
        state_next = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= IDLE;
      valid <= '0;
    end else begin
      state <= state_next;
      if (state == FILL) begin
        valid[fill_index] <= 1'b1;
      end
    end
  end

  // Miss address, response line and arrays
  always_ff @(posedge clk) begin
    if (state == IDLE && miss) begin
      req_addr <= line_addr;
    end
    if (state == WAIT_RESP && resp_match) begin
      fill_data <= mem_resp.data;
    end
    if (state == FILL) begin
      tag_mem[fill_index]  <= fill_tag;
      line_mem[fill_index] <= fill_data;
    end
  end

  // A pending refill is for the line that fetch is still stalled on
  req_matches_fetch_line: assert property (
    @(posedge clk) disable iff (reset)
    req |-> miss && (line_addr == mem_req.addr)
  );

endmodule

`default_nettype wire

//--- mem_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter (
  input  wire logic                      clk,
  input  wire logic                      reset,
  input  wire logic                      icache_req,
  input  wire brisc_mem_pkg::mem_req_t   icache_mem_req,
  output logic                           icache_grant,
  input  wire logic                      data_req,
  input  wire brisc_mem_pkg::mem_req_t   data_mem_req,
  output logic                           data_grant,
  output brisc_mem_pkg::mem_req_t        mem_req,
  output logic                           mem_req_valid,
  input  wire brisc_mem_pkg::mem_resp_t  mem_resp
);

  brisc_mem_pkg::requester_e last_owner;
  logic outstanding;
  logic pick_icache;
  logic pick_data;

  // Round robin, only when no transaction is in flight
  always_comb begin
    pick_icache = 1'b0;
    pick_data   = 1'b0;
    if (!outstanding) begin
      if (icache_req && data_req) begin
        if (last_owner == brisc_mem_pkg::REQ_ICACHE) begin
          pick_data = 1'b1;
        end else begin
          pick_icache = 1'b1;
        end
      end else begin
        pick_icache = icache_req;
        pick_data   = data_req;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      icache_grant  <= 1'b0;
      data_grant    <= 1'b0;
      mem_req_valid <= 1'b0;
      outstanding   <= 1'b0;
      last_owner    <= brisc_mem_pkg::REQ_DATA;
    end else begin
      icache_grant  <= pick_icache;
      data_grant    <= pick_data;
      mem_req_valid <= pick_icache || pick_data;
      if (pick_icache || pick_data) begin
        outstanding <= 1'b1;
      end else if (mem_resp.valid) begin
        outstanding <= 1'b0;
      end
      if (pick_icache) begin
        last_owner <= brisc_mem_pkg::REQ_ICACHE;
      end else if (pick_data) begin
        last_owner <= brisc_mem_pkg::REQ_DATA;
      end
    end
  end

  // Request payload goes out with the grant
  always_ff @(posedge clk) begin
    if (pick_icache) begin
      mem_req <= icache_mem_req;
    end else if (pick_data) begin
      mem_req <= data_mem_req;
    end
  end

  one_grant_at_a_time: assert property (
    @(posedge clk) disable iff (reset)
    !(icache_grant && data_grant)
  );

endmodule

`default_nettype wire

//--- fetch_stage.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_stage #(
  parameter int NUM_LINES = 16
) (
  input  wire logic                                      clk,
  input  wire logic                                      reset,
  input  wire logic                                      stall,
  input  wire brisc_core_pkg::pc_src_e                   pc_src,
  input  wire brisc_core_pkg::xcpt_e                     xcpt,
  input  wire logic [brisc_core_pkg::ADDRESS_WIDTH-1:0]  pc_target,
  output logic [brisc_core_pkg::ILEN-1:0]                instr,
  output logic [brisc_core_pkg::XLEN-1:0]                pc,
  output logic [brisc_core_pkg::XLEN-1:0]                pc_plus4,
  output logic                                           busy,
  output logic                                           icache_req,
  output brisc_mem_pkg::mem_req_t                        icache_mem_req,
  input  wire logic                                      icache_grant,
  input  wire brisc_mem_pkg::mem_resp_t                  mem_resp
);

  logic [brisc_core_pkg::XLEN-1:0] pc_next;
  logic                            icache_miss;

  // Exception wins over redirect
  always_comb begin
    if (xcpt != brisc_core_pkg::NO_XCPT) begin
      pc_next = brisc_core_pkg::PC_XCPT;
    end else if (pc_src == brisc_core_pkg::FROM_A) begin
      pc_next = pc_target;
    end else begin
      pc_next = pc + brisc_core_pkg::PC_INCREMENT;
    end
  end

  assign pc_plus4 = pc_next;
  assign busy     = icache_miss;

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= brisc_core_pkg::PC_BOOT;
    end else if (!busy && !stall) begin
      pc <= pc_next;
    end
  end

  icache #(
    .NUM_LINES (NUM_LINES)
  ) i_icache (
    .clk       (clk),
    .reset     (reset),
    .addr      (pc),
    .read_data (instr),
    .miss      (icache_miss),
    .req       (icache_req),
    .mem_req   (icache_mem_req),
    .grant     (icache_grant),
    .mem_resp  (mem_resp)
  );

  pc_word_aligned: assert property (
    @(posedge clk) disable iff (reset)
    pc[1:0] == 2'b00
  );

endmodule

`default_nettype wire

//--- fetch_top.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_top #(
  parameter int NUM_LINES = 16
) (
  input  wire logic                                      clk,
  input  wire logic                                      reset,
  // Core side
  input  wire logic                                      stall,
  input  wire brisc_core_pkg::pc_src_e                   pc_src,
  input  wire brisc_core_pkg::xcpt_e                     xcpt,
  input  wire logic [brisc_core_pkg::ADDRESS_WIDTH-1:0]  pc_target,
  output logic [brisc_core_pkg::ILEN-1:0]                instr,
  output logic [brisc_core_pkg::XLEN-1:0]                pc,
  output logic [brisc_core_pkg::XLEN-1:0]                pc_plus4,
  output logic                                           busy,
  // Data side
  input  wire logic                                      data_req,
  input  wire brisc_mem_pkg::mem_req_t                   data_mem_req,
  output logic                                           data_grant,
  // Memory port
  output brisc_mem_pkg::mem_req_t                        mem_req,
  output logic                                           mem_req_valid,
  input  wire brisc_mem_pkg::mem_resp_t                  mem_resp
);

  logic                    icache_req;
  logic                    icache_grant;
  brisc_mem_pkg::mem_req_t icache_mem_req;

  fetch_stage #(
    .NUM_LINES (NUM_LINES)
  ) i_fetch_stage (
    .clk            (clk),
    .reset          (reset),
    .stall          (stall),
    .pc_src         (pc_src),
    .xcpt           (xcpt),
    .pc_target      (pc_target),
    .instr          (instr),
    .pc             (pc),
    .pc_plus4       (pc_plus4),
    .busy           (busy),
    .icache_req     (icache_req),
    .icache_mem_req (icache_mem_req),
    .icache_grant   (icache_grant),
    .mem_resp       (mem_resp)
  );

  mem_arbiter i_mem_arbiter (
    .clk            (clk),
    .reset          (reset),
    .icache_req     (icache_req),
    .icache_mem_req (icache_mem_req),
    .icache_grant   (icache_grant),
    .data_req       (data_req),
    .data_mem_req   (data_mem_req),
    .data_grant     (data_grant),
    .mem_req        (mem_req),
    .mem_req_valid  (mem_req_valid),
    .mem_resp       (mem_resp)
  );

endmodule

`default_nettype wire

//--- tb_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mem_model (
  input  wire logic                      clk,
  input  wire logic                      reset,
  input  wire brisc_mem_pkg::mem_req_t   mem_req,
  input  wire logic                      mem_req_valid,
  output brisc_mem_pkg::mem_resp_t       mem_resp
);

  localparam int ILEN = brisc_core_pkg::ILEN;

  int unsigned cycles_left;

  // Word at byte address A holds A ^ 32'hA5A5_0000, word 0 in the low bits
  function automatic logic [brisc_mem_pkg::CACHE_LINE_WIDTH-1:0] line_at(
    input logic [brisc_core_pkg::ADDRESS_WIDTH-1:0] addr
  );
    logic [brisc_mem_pkg::CACHE_LINE_WIDTH-1:0] line;
    line = '0;
    for (int w = 0; w < brisc_mem_pkg::WORDS_PER_LINE; w++) begin
      line[w*ILEN +: ILEN] = (addr + 32'(w * 4)) ^ 32'hA5A5_0000;
    end
    return line;
  endfunction

  // One read at a time, answered 2 to 9 cycles after the request
  always @(posedge clk) begin
    if (reset) begin
      mem_resp <= '0;
      cycles_left <= 0;
    end else begin
      mem_resp.valid <= 1'b0;
      if (mem_req_valid) begin
        mem_resp.addr <= mem_req.addr;
        cycles_left <= 2 + ($urandom % 8);
      end else if (cycles_left == 1) begin
        mem_resp.valid <= 1'b1;
        mem_resp.data <= line_at(mem_resp.addr);
        cycles_left <= 0;
      end else if (cycles_left != 0) begin
        cycles_left <= cycles_left - 1;
      end
    end
  end

endmodule

`default_nettype wire

//--- tb_fetch_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_fetch_top;

  localparam int AW = brisc_core_pkg::ADDRESS_WIDTH;
  localparam int NUM_LINES = 16;
  localparam int NUM_ROWS = 12;
  localparam int TIMEOUT = 100;
  localparam brisc_core_pkg::pc_src_e SEQ = brisc_core_pkg::FROM_PC4;
  localparam brisc_core_pkg::pc_src_e JMP = brisc_core_pkg::FROM_A;
  localparam brisc_core_pkg::xcpt_e NOX = brisc_core_pkg::NO_XCPT;

  typedef struct packed {
    logic                    stall;
    brisc_core_pkg::pc_src_e pc_src;
    brisc_core_pkg::xcpt_e   xcpt;
    logic [AW-1:0]           target;
  } row_t;

  // Each row is applied at the PC left by the row before it
  localparam row_t ROWS [NUM_ROWS] = '{
    row_t'{1'b0, SEQ, NOX, 32'h0000_0000},
    row_t'{1'b0, SEQ, NOX, 32'h0000_0000},
    row_t'{1'b0, SEQ, NOX, 32'h0000_0000},
    row_t'{1'b0, SEQ, NOX, 32'h0000_0000},
    row_t'{1'b1, JMP, NOX, 32'h0000_0500},
    // 0x200 aliases the boot line
    row_t'{1'b0, JMP, NOX, 32'h0000_0200},
    row_t'{1'b0, JMP, brisc_core_pkg::XCPT_ILLEGAL, 32'h0000_0300},
    row_t'{1'b0, JMP, NOX, 32'h0000_010C},
    row_t'{1'b0, SEQ, NOX, 32'h0000_0000},
    row_t'{1'b0, SEQ, brisc_core_pkg::XCPT_ECALL, 32'h0000_0000},
    row_t'{1'b0, JMP, NOX, 32'h0000_01FC},
    row_t'{1'b0, SEQ, NOX, 32'h0000_0000}
  };

  logic clk;
  logic reset;
  logic stall;
  brisc_core_pkg::pc_src_e pc_src;
  brisc_core_pkg::xcpt_e xcpt;
  logic [AW-1:0] pc_target;
  logic [brisc_core_pkg::ILEN-1:0] instr;
  logic [brisc_core_pkg::XLEN-1:0] pc;
  logic [brisc_core_pkg::XLEN-1:0] pc_plus4;
  logic busy;
  logic data_req;
  brisc_mem_pkg::mem_req_t data_mem_req;
  logic data_grant;
  brisc_mem_pkg::mem_req_t mem_req;
  logic mem_req_valid;
  brisc_mem_pkg::mem_resp_t mem_resp;
  logic [AW-1:0] model_pc;

  fetch_top #(.NUM_LINES(NUM_LINES)) i_dut (.*);
  tb_mem_model i_mem (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic abort_run();
    $display("TESTS FAILED");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_pc(input string name, input logic [AW-1:0] got,
                          input logic [AW-1:0] exp);
    if (got !== exp) begin
      $display("[ERROR] %0t: %s is %h, expected %h", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_word(input string name, input logic [brisc_core_pkg::ILEN-1:0] got,
                            input logic [brisc_core_pkg::ILEN-1:0] exp);
    if (got !== exp) begin
      $display("[ERROR] %0t: %s is %h, expected %h", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_grant(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("[ERROR] %0t: %s is %b, expected %b", $time, name, got, exp);
      abort_run();
    end
  endtask

  function automatic logic [brisc_core_pkg::ILEN-1:0] expected_word(input logic [AW-1:0] a);
    return a ^ 32'hA5A5_0000;
  endfunction

  // Exception first, then redirect, then sequential
  function automatic logic [AW-1:0] select_next_pc(input row_t r, input logic [AW-1:0] cur);
    if (r.xcpt != NOX) begin
      return brisc_core_pkg::PC_XCPT;
    end else if (r.pc_src == JMP) begin
      return r.target;
    end
    return cur + 32'd4;
  endfunction

  task automatic wait_fetch();
    int n;
    n = 0;
    while (busy) begin
      if (n == TIMEOUT) begin
        $display("Fetch at pc %h still busy after %0d cycles", pc, n);
        abort_run();
      end
      @(posedge clk);
      #5;
      n++;
    end
  endtask

  // Grants sampled mid-cycle
  always @(negedge clk) begin
    if (!reset) begin
      check_grant("icache_grant & data_grant", i_dut.icache_grant && data_grant, 1'b0);
    end
  end

  // Data-side reads at random gaps, each one granted in time
  initial begin : data_traffic
    int n;
    data_req = 1'b0;
    data_mem_req = '0;
    repeat (12) @(posedge clk);
    forever begin
      repeat (1 + $urandom % 24) @(posedge clk);
      #5;
      data_mem_req.addr = {1'b1, 27'($urandom), 4'h0};
      data_req = 1'b1;
      n = 0;
      while (!data_grant) begin
        if (n == TIMEOUT) begin
          $display("No data_grant within %0d cycles for %h", n, data_mem_req.addr);
          abort_run();
        end
        @(posedge clk);
        #5;
        n++;
      end
      data_req = 1'b0;
    end
  end

  initial begin : main_sequence
    logic [AW-1:0] exp_next;
    void'($urandom(62));
    reset = 1'b1;
    stall = 1'b0;
    pc_src = SEQ;
    xcpt = NOX;
    pc_target = '0;
    repeat (10) @(posedge clk);
    #5;
    reset = 1'b0;
    model_pc = brisc_core_pkg::PC_BOOT;
    for (int i = 0; i <= NUM_ROWS; i++) begin
      wait_fetch();
      check_pc("pc", pc, model_pc);
      check_word("instr", instr, expected_word(model_pc));
      if (i < NUM_ROWS) begin
        stall = ROWS[i].stall;
        pc_src = ROWS[i].pc_src;
        xcpt = ROWS[i].xcpt;
        pc_target = ROWS[i].target;
        exp_next = select_next_pc(ROWS[i], model_pc);
        // pc_plus4 shows the selected next PC even while stalled
        @(negedge clk);
        check_pc("pc_plus4", pc_plus4, exp_next);
        if (!ROWS[i].stall) begin
          model_pc = exp_next;
        end
        @(posedge clk);
        #5;
      end
    end
    $display("TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- brisc_fetch.f
brisc_core_pkg.sv
brisc_mem_pkg.sv
icache.sv
mem_arbiter.sv
fetch_stage.sv
fetch_top.sv
tb_mem_model.sv
tb_fetch_top.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the fetch testbench with Verilator
cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_fetch_top -f brisc_fetch.f -o tb_fetch_top
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_fetch_top > "$log" 2>&1
sim_status=$?
cat "$log"

if grep -q "TESTS FAILED" "$log"; then
  exit 1
fi
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi
exit 0
